/* compile.f */
common/cp0Pkg.sv
common/excCommitIf.sv
hw/excArbiter.sv
cp0/cp0Regs.sv
hw/trapRedirect.sv
hw/cp0Top.sv
verification/cp0Tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module cp0Tb -o cp0Sim

if ./obj_dir/cp0Sim | tee /dev/stderr | grep -q "Test passed"; then
    exit 0
else
    exit 1
fi

/* verification/cp0Tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0Tb;

    localparam int MaxRows = 128;

    logic        clk;
    logic        reset_i;
    logic        commitValid;
    cp0Pkg::excFlags_t flags;
    logic [31:0] pc;
    logic        isDelaySlot;
    logic [31:0] badAddr;
    logic [5:0]  hwInt;
    logic        cp0Wr;
    logic [4:0]  cp0WrAddr;
    logic [31:0] cp0WrData;
    logic [4:0]  cp0RdAddr;
    logic [31:0] cp0RdData;
    logic        flush;
    logic [31:0] redirectPc;
    logic        timerInt;

    // stimulus table with one row per commit cycle
    string       rowName[MaxRows];
    logic        rowValid[MaxRows];
    logic [7:0]  rowFlags[MaxRows];
    logic [31:0] rowPc[MaxRows];
    logic        rowDs[MaxRows];
    logic [31:0] rowBad[MaxRows];
    logic [5:0]  rowHw[MaxRows];
    logic        rowWen[MaxRows];
    logic [4:0]  rowWa[MaxRows];
    logic [31:0] rowWd[MaxRows];
    logic [4:0]  rowRa[MaxRows];
    logic        expFlush[MaxRows];
    logic [31:0] expRedirect[MaxRows];
    logic [31:0] expRead[MaxRows];
    logic        expTimer[MaxRows];
    int          nRows = 0;
    int          cycles = 0;

    // reference model state
    logic [31:0] mCount;
    logic [31:0] mCompare;
    logic [31:0] mStatus;
    logic [31:0] mCause;
    logic [31:0] mEpc;
    logic [31:0] mBadV;
    logic        mHalf;
    logic        mTimer;
    logic [31:0] rngState = 32'd50967;

    cp0Top dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .commitValid_i (commitValid),
        .excFlags_i    (flags),
        .pc_i          (pc),
        .isDelaySlot_i (isDelaySlot),
        .badAddr_i     (badAddr),
        .hwInt_i       (hwInt),
        .cp0Wr_i       (cp0Wr),
        .cp0WrAddr_i   (cp0WrAddr),
        .cp0WrData_i   (cp0WrData),
        .cp0RdAddr_i   (cp0RdAddr),
        .cp0RdData_o   (cp0RdData),
        .flush_o       (flush),
        .redirectPc_o  (redirectPc),
        .timerInt_o    (timerInt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // xorshift32
    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [31:0] readModel(input logic [4:0] addr);
        case (addr)
            cp0Pkg::RegBadVAddr: return mBadV;
            cp0Pkg::RegCount:    return mCount;
            cp0Pkg::RegCompare:  return mCompare;
            cp0Pkg::RegStatus:   return mStatus;
            cp0Pkg::RegCause:    return mCause;
            cp0Pkg::RegEpc:      return mEpc;
            default:             return 32'd0;
        endcase
    endfunction

    // ****************************************
    // table builder with reference model
    // ****************************************
    task automatic addRow(input string name, input logic valid, input logic [7:0] fl,
                          input logic [31:0] pcIn, input logic ds, input logic [31:0] bad,
                          input logic [5:0] hw, input logic wen, input logic [4:0] wa,
                          input logic [31:0] wd, input logic [4:0] ra);
        logic        intPend;
        logic        take;
        logic        eret;
        logic        setBad;
        logic [4:0]  code;
        logic [31:0] nCount;
        logic [31:0] nCompare;
        logic [31:0] nStatus;
        logic [31:0] nCause;
        logic [31:0] nEpc;
        logic [31:0] nBadV;
        logic        nHalf;
        logic        nTimer;
        intPend = mStatus[0] & ~mStatus[1] & (|(mCause[15:8] & mStatus[15:8]));
        take    = valid & (intPend | (|fl[7:1]));
        setBad  = 1'b0;
        code    = cp0Pkg::ExcInt;
        if (valid && !intPend) begin
            casez (fl[7:1])        // priority order with fetch error first
                7'b1??????: begin
                    code   = cp0Pkg::ExcAdel;
                    setBad = 1'b1;
                end
                7'b01?????: code = cp0Pkg::ExcRi;
                7'b001????: code = cp0Pkg::ExcSys;
                7'b0001???: code = cp0Pkg::ExcBp;
                7'b00001??: code = cp0Pkg::ExcOv;
                7'b000001?: begin
                    code   = cp0Pkg::ExcAdes;
                    setBad = 1'b1;
                end
                7'b0000001: begin
                    code   = cp0Pkg::ExcAdel;
                    setBad = 1'b1;
                end
                default: ;
            endcase
        end
        eret = valid & fl[0] & ~take;
        nCause = mCause;
        nCause[15:10] = {hw[5] | mTimer, hw[4:0]};   // IP7 carries the timer
        nHalf    = ~mHalf;
        nCount   = mHalf ? mCount + 32'd1 : mCount;
        nTimer   = mTimer | ((mCompare != 32'd0) && (mCount == mCompare));
        nCompare = mCompare;
        nStatus  = mStatus;
        nEpc     = mEpc;
        nBadV    = mBadV;
        if (wen) begin
            case (wa)
                cp0Pkg::RegCount: begin
                    nCount = wd;
                    nHalf  = 1'b0;
                end
                cp0Pkg::RegCompare: begin
                    nCompare = wd;
                    nTimer   = 1'b0;
                end
                cp0Pkg::RegStatus: begin
                    nStatus[15:8] = wd[15:8];
                    nStatus[1:0]  = wd[1:0];
                end
                cp0Pkg::RegCause:   nCause[9:8] = wd[9:8];
                cp0Pkg::RegEpc:     nEpc = wd;
                default: ;
            endcase
        end
        if (take) begin                          // exception beats MTC0
            if (!mStatus[1]) begin
                nEpc       = ds ? pcIn - 32'd4 : pcIn;
                nCause[31] = ds;
            end
            nStatus[1]  = 1'b1;
            nCause[6:2] = code;
            if (setBad) nBadV = fl[7] ? pcIn : bad;
        end else if (eret) begin
            nStatus[1] = 1'b0;
        end
        rowName[nRows]  = name;
        rowValid[nRows] = valid;
        rowFlags[nRows] = fl;
        rowPc[nRows]    = pcIn;
        rowDs[nRows]    = ds;
        rowBad[nRows]   = bad;
        rowHw[nRows]    = hw;
        rowWen[nRows]   = wen;
        rowWa[nRows]    = wa;
        rowWd[nRows]    = wd;
        rowRa[nRows]    = ra;
        expFlush[nRows]    = take | eret;
        expRedirect[nRows] = take ? cp0Pkg::ExcVector : mEpc;   // eret uses old EPC
        {mCount, mCompare, mStatus, mCause, mEpc, mBadV} =
            {nCount, nCompare, nStatus, nCause, nEpc, nBadV};
        mHalf  = nHalf;
        mTimer = nTimer;
        expRead[nRows]  = readModel(ra);   // MFC0 after the edge
        expTimer[nRows] = mTimer;
        nRows++;
    endtask

    task automatic idleRow(input string name, input logic [5:0] hw, input logic [4:0] ra);
        addRow(name, 1'b0, 8'h00, 32'd0, 1'b0, 32'd0, hw, 1'b0, 5'd0, 32'd0, ra);
    endtask

    task automatic writeRow(input string name, input logic [4:0] wa, input logic [31:0] wd,
                            input logic [4:0] ra);
        addRow(name, 1'b0, 8'h00, 32'd0, 1'b0, 32'd0, 6'd0, 1'b1, wa, wd, ra);
    endtask

    task automatic compareValue(input string testName, input string field,
                                input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s %s expected %h actual %h", testName, field, expected, actual);
            $display("Test failed");
            $fatal(1, "mismatch on %s", field);
        end
    endtask

    // ****************************************
    // table contents
    // ****************************************
    task automatic buildTable();
        logic [31:0] p;
        logic [31:0] a;
        mCount   = 0;
        mCompare = 0;
        mStatus  = cp0Pkg::StatusReset;
        mCause   = 0;
        mEpc     = 0;
        mBadV    = 0;
        mHalf    = 0;
        mTimer   = 0;
        idleRow("resetCount", 6'd0, cp0Pkg::RegCount);   // first edge leaves count at zero
        idleRow("resetStatus", 6'd0, cp0Pkg::RegStatus);
        idleRow("resetCause", 6'd0, cp0Pkg::RegCause);
        idleRow("resetEpc", 6'd0, cp0Pkg::RegEpc);
        for (int k = 0; k < 7; k++) begin         // fetch error first so BadVAddr is set
            p = nextRand() & 32'hFFFF_FFFC;
            a = nextRand();
            writeRow($sformatf("clrExl%0d", k), cp0Pkg::RegStatus, 32'd0, cp0Pkg::RegStatus);
            addRow($sformatf("flag%0d", k), 1'b1, 8'h80 >> k, p, a[0], a, 6'd0,
                   1'b0, 5'd0, 32'd0, cp0Pkg::RegCause);
            idleRow($sformatf("epc%0d", k), 6'd0, cp0Pkg::RegEpc);
            idleRow($sformatf("badv%0d", k), 6'd0, cp0Pkg::RegBadVAddr);
        end
        writeRow("multiClr", cp0Pkg::RegStatus, 32'd0, cp0Pkg::RegStatus);
        addRow("multiFlags", 1'b1, 8'h26, nextRand() & 32'hFFFF_FFFC, 1'b0, nextRand(),
               6'd0, 1'b0, 5'd0, 32'd0, cp0Pkg::RegCause);
        // slot after a flush is a bubble
        idleRow("multiEpc", 6'd0, cp0Pkg::RegEpc);
        addRow("nestedOv", 1'b1, 8'h08, nextRand() & 32'hFFFF_FFFC, 1'b1, 32'd0,
               6'd0, 1'b0, 5'd0, 32'd0, cp0Pkg::RegCause);
        idleRow("nestedEpc", 6'd0, cp0Pkg::RegEpc);
        writeRow("eretEpcWr", cp0Pkg::RegEpc, nextRand() & 32'hFFFF_FFFC, cp0Pkg::RegEpc);
        addRow("eret", 1'b1, 8'h01, 32'd0, 1'b0, 32'd0, 6'd0, 1'b0, 5'd0, 32'd0,
               cp0Pkg::RegStatus);
        writeRow("cntWr", cp0Pkg::RegCount, 32'd0, cp0Pkg::RegCount);
        writeRow("cmpWr", cp0Pkg::RegCompare, 32'd10, cp0Pkg::RegCompare);
        for (int j = 0; j < 26; j++) begin
            idleRow($sformatf("timer%0d", j), 6'd0,
                    (j < 22) ? cp0Pkg::RegCount : cp0Pkg::RegCause);
        end
        writeRow("cmpClr", cp0Pkg::RegCompare, 32'd0, cp0Pkg::RegCause);
        idleRow("ip7Drop", 6'd0, cp0Pkg::RegCause);
        // hw line 0 is IP2 with mask bit 10
        addRow("hwImOnly", 1'b0, 8'h00, 32'd0, 1'b0, 32'd0, 6'd1, 1'b1,
               cp0Pkg::RegStatus, 32'h0000_0400, cp0Pkg::RegCause);
        addRow("hwNoIe", 1'b1, 8'h00, 32'h100, 1'b0, 32'd0, 6'd1, 1'b0, 5'd0, 32'd0,
               cp0Pkg::RegCause);
        addRow("hwIeOnly", 1'b0, 8'h00, 32'd0, 1'b0, 32'd0, 6'd1, 1'b1,
               cp0Pkg::RegStatus, 32'h0000_0001, cp0Pkg::RegStatus);
        addRow("hwNoIm", 1'b1, 8'h00, 32'h104, 1'b0, 32'd0, 6'd1, 1'b0, 5'd0, 32'd0,
               cp0Pkg::RegCause);
        addRow("hwEnable", 1'b0, 8'h00, 32'd0, 1'b0, 32'd0, 6'd1, 1'b1,
               cp0Pkg::RegStatus, 32'h0000_0401, cp0Pkg::RegStatus);
        addRow("hwTaken", 1'b1, 8'h00, 32'h108, 1'b0, 32'd0, 6'd1, 1'b0, 5'd0, 32'd0,
               cp0Pkg::RegCause);
        addRow("hwExlBlk", 1'b1, 8'h00, 32'h10C, 1'b0, 32'd0, 6'd1, 1'b0, 5'd0, 32'd0,
               cp0Pkg::RegStatus);
    endtask

    // run limit from table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > nRows * 4 + 200) begin
            $display("Timeout, the table did not finish in time");
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        reset_i     = 1'b1;
        commitValid = 1'b0;
        flags       = '0;
        pc          = 32'd0;
        isDelaySlot = 1'b0;
        badAddr     = 32'd0;
        hwInt       = 6'd0;
        cp0Wr       = 1'b0;
        cp0WrAddr   = 5'd0;
        cp0WrData   = 32'd0;
        cp0RdAddr   = 5'd0;
        buildTable();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        for (int i = 0; i < nRows; i++) begin
            commitValid = rowValid[i];
            flags       = rowFlags[i];
            pc          = rowPc[i];
            isDelaySlot = rowDs[i];
            badAddr     = rowBad[i];
            hwInt       = rowHw[i];
            cp0Wr       = rowWen[i];
            cp0WrAddr   = rowWa[i];
            cp0WrData   = rowWd[i];
            cp0RdAddr   = rowRa[i];
            @(negedge clk);             // commit edge has passed
            compareValue(rowName[i], "flush", 32'(expFlush[i]), 32'(flush));
            if (expFlush[i]) compareValue(rowName[i], "redirect", expRedirect[i], redirectPc);
            compareValue(rowName[i], "rdData", expRead[i], cp0RdData);
            compareValue(rowName[i], "timerInt", 32'(expTimer[i]), 32'(timerInt));
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/cp0Top.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0Top (
    input  wire logic               clk,
    input  wire logic               reset_i,
    // commit slot
    input  wire logic               commitValid_i,
    input  wire cp0Pkg::excFlags_t  excFlags_i,
    input  wire logic [31:0]        pc_i,
    input  wire logic               isDelaySlot_i,
    input  wire logic [31:0]        badAddr_i,
    // interrupts
    input  wire logic [5:0]         hwInt_i,
    // MTC0 / MFC0
    input  wire logic               cp0Wr_i,
    input  wire logic [4:0]         cp0WrAddr_i,
    input  wire logic [31:0]        cp0WrData_i,
    input  wire logic [4:0]         cp0RdAddr_i,
    output logic [31:0]             cp0RdData_o,
    // to fetch
    output logic                    flush_o,
    output logic [31:0]             redirectPc_o,
    output logic                    timerInt_o
);

    logic [31:0] status;
    logic [31:0] cause;
    logic [31:0] epc;

    excCommitIf excBus ();  // arbiter -> regs, redirect

    // ****************************************
    // input side, register file, output side
    // ****************************************
    excArbiter uArbiter (
        .commitValid_i (commitValid_i),
        .flags_i       (excFlags_i),
        .pc_i          (pc_i),
        .isDelaySlot_i (isDelaySlot_i),
        .badAddr_i     (badAddr_i),
        .status_i      (status),
        .cause_i       (cause),
        .exc           (excBus.source)
    );

    cp0Regs uRegs (
        .clk        (clk),
        .reset_i    (reset_i),
        .hwInt_i    (hwInt_i),
        .wrEn_i     (cp0Wr_i),
        .wrAddr_i   (cp0WrAddr_i),
        .wrData_i   (cp0WrData_i),
        .rdAddr_i   (cp0RdAddr_i),
        .rdData_o   (cp0RdData_o),
        .status_o   (status),
        .cause_o    (cause),
        .epc_o      (epc),
        .timerInt_o (timerInt_o),
        .exc        (excBus.sink)
    );

    trapRedirect uRedirect (
        .clk          (clk),
        .reset_i      (reset_i),
        .epc_i        (epc),
        .flush_o      (flush_o),
        .redirectPc_o (redirectPc_o),
        .exc          (excBus.sink)
    );

endmodule

`default_nettype wire

/* hw/trapRedirect.sv */
`timescale 1ns/1ps
`default_nettype none

module trapRedirect (
    input  wire logic         clk,
    input  wire logic         reset_i,
    input  wire logic [31:0]  epc_i,        // current EPC, eret target
    output logic              flush_o,      // one cycle after commit
    output logic [31:0]       redirectPc_o,
    excCommitIf.sink          exc
);

    logic        flushQ;
    logic [31:0] redirectQ;

    // ****************************************
    // flush pulse
    // ****************************************
    always_ff @(posedge clk) begin
        if (reset_i) begin
            flushQ <= 1'b0;
        end else begin
            flushQ <= exc.take | exc.eret;
        end
    end

    // target, only looked at while flushQ is high
    always_ff @(posedge clk) begin
        if (exc.take) begin
            redirectQ <= cp0Pkg::ExcVector;
        end else begin
            redirectQ <= epc_i;   // eret returns to pre-update EPC
        end
    end

    assign flush_o      = flushQ;
    assign redirectPc_o = redirectQ;

    // pipe is emptied by the flush, so the next slot cannot trap again
    flushOneCycle: assert property (
        @(posedge clk) disable iff (reset_i) flush_o |=> !flush_o
    ) else $error("trapRedirect: flush held for two cycles");

endmodule

`default_nettype wire

/* cp0/cp0Regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0Regs (
    input  wire logic         clk,
    input  wire logic         reset_i,
    input  wire logic [5:0]   hwInt_i,    // external interrupt lines
    input  wire logic         wrEn_i,     // MTC0
    input  wire logic [4:0]   wrAddr_i,
    input  wire logic [31:0]  wrData_i,
    input  wire logic [4:0]   rdAddr_i,   // MFC0
    output logic [31:0]       rdData_o,
    output logic [31:0]       status_o,
    output logic [31:0]       cause_o,
    output logic [31:0]       epc_o,
    output logic              timerInt_o,
    excCommitIf.sink          exc
);

    logic [31:0] badVAddrQ;
    logic [31:0] countQ;
    logic [31:0] compareQ;
    logic [31:0] statusQ;
    logic [31:0] causeQ;
    logic [31:0] epcQ;
    logic        countHalf;   // count ticks every second clk
    logic        timerIntQ;
    logic        timerHit;    // count matched a live compare

    assign timerHit = (compareQ != 32'd0) && (countQ == compareQ);

    // ****************************************
    // control state, timer, MTC0, exceptions
    // ****************************************
    always_ff @(posedge clk) begin
        if (reset_i) begin
            countQ    <= 32'd0;
            compareQ  <= 32'd0;
            statusQ   <= cp0Pkg::StatusReset;
            causeQ    <= 32'd0;
            epcQ      <= 32'd0;
            countHalf <= 1'b0;
            timerIntQ <= 1'b0;
        end else begin
            // IP[7:2] sampled every cycle, timer folded into IP7
            causeQ[15:10] <= {hwInt_i[5] | timerIntQ, hwInt_i[4:0]};

            // timer
            countHalf <= ~countHalf;
            if (countHalf) begin
                countQ <= countQ + 32'd1;
            end
            if (timerHit) begin
                timerIntQ <= 1'b1;   // sticky until compare is rewritten
            end

            // MTC0, only the writable fields
            if (wrEn_i) begin
                case (wrAddr_i)
                    cp0Pkg::RegCount: begin
                        countQ    <= wrData_i;
                        countHalf <= 1'b0;   // restart the divide by two
                    end
                    cp0Pkg::RegCompare: begin
                        compareQ  <= wrData_i;
                        timerIntQ <= 1'b0;   // ack timer
                    end
                    cp0Pkg::RegStatus: begin
                        statusQ[15:8]              <= wrData_i[15:8];  // IM
                        statusQ[cp0Pkg::StatusExl] <= wrData_i[cp0Pkg::StatusExl];
                        statusQ[cp0Pkg::StatusIe]  <= wrData_i[cp0Pkg::StatusIe];
                    end
                    cp0Pkg::RegCause: begin
                        causeQ[9:8] <= wrData_i[9:8];  // sw interrupts only
                    end
                    cp0Pkg::RegEpc: begin
                        epcQ <= wrData_i;
                    end
                    default: ;  // BadVAddr and others read only
                endcase
            end

            // exception update, placed last so it wins over MTC0
            if (exc.take) begin
                // nested exception keeps the first epc
                if (!statusQ[cp0Pkg::StatusExl]) begin
                    epcQ       <= exc.epc;
                    causeQ[31] <= exc.bd;
                end
                statusQ[cp0Pkg::StatusExl] <= 1'b1;
                causeQ[6:2]                <= exc.code;
            end else if (exc.eret) begin
                statusQ[cp0Pkg::StatusExl] <= 1'b0;   // back to user level
            end
        end
    end

    // faulting address, payload only
    always_ff @(posedge clk) begin
        if (exc.take && exc.setBadVAddr) begin
            badVAddrQ <= exc.badVAddr;
        end
    end

    // ****************************************
    // MFC0 read mux
    // ****************************************
    always_comb begin
        case (rdAddr_i)
            cp0Pkg::RegBadVAddr: rdData_o = badVAddrQ;
            cp0Pkg::RegCount:    rdData_o = countQ;
            cp0Pkg::RegCompare:  rdData_o = compareQ;
            cp0Pkg::RegStatus:   rdData_o = statusQ;
            cp0Pkg::RegCause:    rdData_o = causeQ;
            cp0Pkg::RegEpc:      rdData_o = epcQ;
            default:             rdData_o = 32'd0;   // unimplemented regs
        endcase
    end

    assign status_o   = statusQ;
    assign cause_o    = causeQ;
    assign epc_o      = epcQ;
    assign timerInt_o = timerIntQ;

    // arbiter sees CU0 set and interrupts masked right out of reset
    statusAfterReset: assert property (
        @(posedge clk) reset_i |=> (status_o == cp0Pkg::StatusReset)
    ) else $error("cp0Regs: Status not at reset value");

endmodule

`default_nettype wire

/* hw/excArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module excArbiter (
    input  wire logic               commitValid_i,  // commit slot holds an instruction
    input  wire cp0Pkg::excFlags_t  flags_i,
    input  wire logic [31:0]        pc_i,           // pc of committing instruction
    input  wire logic               isDelaySlot_i,
    input  wire logic [31:0]        badAddr_i,      // data address from mem stage
    input  wire logic [31:0]        status_i,       // live Status from regs
    input  wire logic [31:0]        cause_i,        // live Cause from regs
    excCommitIf.source              exc
);

    logic intPending;   // unmasked interrupt waiting
    logic [7:0] intHit; // IP & IM

    // ****************************************
    // interrupt qualification
    // ****************************************
    assign intHit     = cause_i[15:8] & status_i[15:8];
    assign intPending = status_i[cp0Pkg::StatusIe] & ~status_i[cp0Pkg::StatusExl]
                      & (|intHit);

    // ****************************************
    // priority pick
    // ****************************************
    always_comb begin
        exc.take        = 1'b0;
        exc.code        = cp0Pkg::ExcInt;
        exc.setBadVAddr = 1'b0;
        exc.badVAddr    = badAddr_i;   // data errors by default

        if (commitValid_i) begin
            if (intPending) begin
                exc.take = 1'b1;                 // code stays ExcInt
            end else if (flags_i.fetchAddrErr) begin
                exc.take        = 1'b1;
                exc.code        = cp0Pkg::ExcAdel;
                exc.badVAddr    = pc_i;          // fetch fault reports the pc
                exc.setBadVAddr = 1'b1;
            end else if (flags_i.reservedInst) begin
                exc.take = 1'b1;
                exc.code = cp0Pkg::ExcRi;
            end else if (flags_i.syscall) begin
                exc.take = 1'b1;
                exc.code = cp0Pkg::ExcSys;
            end else if (flags_i.breakpoint) begin
                exc.take = 1'b1;
                exc.code = cp0Pkg::ExcBp;
            end else if (flags_i.overflow) begin
                exc.take = 1'b1;
                exc.code = cp0Pkg::ExcOv;
            end else if (flags_i.storeAddrErr) begin
                exc.take        = 1'b1;
                exc.code        = cp0Pkg::ExcAdes;
                exc.setBadVAddr = 1'b1;
            end else if (flags_i.loadAddrErr) begin
                exc.take        = 1'b1;
                exc.code        = cp0Pkg::ExcAdel;
                exc.setBadVAddr = 1'b1;
            end
        end

        // eret only goes through on a clean commit
        exc.eret = commitValid_i & flags_i.eret & ~exc.take;

        // delay slot restarts at the branch
        exc.bd  = isDelaySlot_i;
        exc.epc = isDelaySlot_i ? (pc_i - 32'd4) : pc_i;
    end

endmodule

`default_nettype wire

/* common/excCommitIf.sv */
`timescale 1ns/1ps
`default_nettype none

// one resolved exception per cycle, arbiter -> regs and redirect
// valid in the cycle it is driven, no handshake
interface excCommitIf;

    logic        take;         // exception taken this cycle
    logic        eret;         // eret commits this cycle
    logic [4:0]  code;         // ExcCode for Cause
    logic [31:0] epc;          // return address
    logic        bd;           // faulting inst sat in a delay slot
    logic [31:0] badVAddr;     // faulting address
    logic        setBadVAddr;  // load BadVAddr with it

    // arbiter side
    modport source (
        output take,
        output eret,
        output code,
        output epc,
        output bd,
        output badVAddr,
        output setBadVAddr
    );

    // consumers
    modport sink (
        input take,
        input eret,
        input code,
        input epc,
        input bd,
        input badVAddr,
        input setBadVAddr
    );

endinterface

`default_nettype wire

/* common/cp0Pkg.sv */
`default_nettype none

package cp0Pkg;

    // ****************************************
    // CP0 register numbers (MTC0/MFC0 rd field)
    // ****************************************
    localparam logic [4:0] RegBadVAddr = 5'd8;   // last faulting address
    localparam logic [4:0] RegCount    = 5'd9;   // free-running timer
    localparam logic [4:0] RegCompare  = 5'd11;  // timer match value
    localparam logic [4:0] RegStatus   = 5'd12;
    localparam logic [4:0] RegCause    = 5'd13;
    localparam logic [4:0] RegEpc      = 5'd14;  // return address

    // ****************************************
    // ExcCode values, go to Cause[6:2]
    // ****************************************
    localparam logic [4:0] ExcInt  = 5'd0;   // interrupt
    localparam logic [4:0] ExcAdel = 5'd4;   // addr error on load or fetch
    localparam logic [4:0] ExcAdes = 5'd5;   // addr error on store
    localparam logic [4:0] ExcSys  = 5'd8;   // syscall
    localparam logic [4:0] ExcBp   = 5'd9;   // break
    localparam logic [4:0] ExcRi   = 5'd10;  // reserved instruction
    localparam logic [4:0] ExcOv   = 5'd12;  // integer overflow

    // commit-stage flags, highest priority first
    // (interrupt is above all of these but comes from Cause/Status, not the pipe)
    typedef struct packed {
        logic fetchAddrErr;  // pc misaligned at fetch
        logic reservedInst;
        logic syscall;
        logic breakpoint;
        logic overflow;
        logic storeAddrErr;
        logic loadAddrErr;
        logic eret;          // not an exception, just the return
    } excFlags_t;

    // ****************************************
    // fixed addresses and reset values
    // ****************************************
    localparam logic [31:0] ExcVector   = 32'hBFC0_0380;  // general handler, BEV=1
    localparam logic [31:0] StatusReset = 32'h1000_0000;  // CU0 set, all else clear

    // Status bit positions
    localparam int StatusExl = 1;  // exception level
    localparam int StatusIe  = 0;  // global interrupt enable

endpackage

`default_nettype wire
